/* verilog/feed_pkg.sv */
package feed_pkg;

   // Command opcodes carried in the second byte of a frame
   typedef enum logic [7:0] {
      OP_LED  = 8'h01,                       // Write LED value
      OP_GPS  = 8'h02,                       // Write GPS status
      OP_STOP = 8'h03                        // Disarm
   } opcode_e;

   // Frame parser states
   typedef enum logic [1:0] {
      ST_SYNC,                               // Hunting for sync byte
      ST_OPCODE,                             // Expecting opcode
      ST_DATA,                               // Expecting data byte
      ST_ISSUE                               // Command out this cycle
   } parse_state_e;

   localparam logic [7:0] SYNC_BYTE = 8'hA5; // Frame start marker

   // One decoded command
   typedef struct packed {
      opcode_e    opcode;                    // What to do
      logic [7:0] data;                      // Payload byte
   } feed_cmd_t;

endpackage

/* verilog/board_pkg.sv */
package board_pkg;

   // Segments g..a, active low
   typedef logic [6:0] seg7_t;

   // Everything the board displays
   typedef struct packed {
      logic [7:0] leds;                      // LED register
      logic [7:0] gps;                       // GPS status register
      logic       armed;                     // Writes enabled
      logic       frame_err;                 // Sticky bad opcode
      logic       overrun;                   // Sticky dropped byte
   } disp_t;

endpackage

/* verilog/key_debounce.sv */
`timescale 1ns/1ps

module key_debounce #(
   parameter int DEBOUNCE_CYCLES = 100
) (
   input  logic CLOCK_50,
   input  logic rst,
   input  logic key_n,                       // Raw push button, low when pressed
   output logic start_pressed                // One pulse per press
);

   localparam int CW = $clog2(DEBOUNCE_CYCLES + 1);

   logic [1:0]    key_sync;                  // Two-flop synchroniser
   logic          key_level;                 // Accepted level, 1 = released
   logic [CW-1:0] cnt;                       // Stability down-counter

   always_ff @(posedge CLOCK_50) begin
      if (rst) begin
         key_sync      <= 2'b11;
         key_level     <= 1'b1;
         cnt           <= CW'(DEBOUNCE_CYCLES);
         start_pressed <= 1'b0;
      end else begin
         key_sync      <= {key_sync[0], key_n};
         start_pressed <= 1'b0;
         if (key_sync[1] == key_level) begin
            cnt <= CW'(DEBOUNCE_CYCLES);     // No change seen, restart window
         end else if (cnt == '0) begin
            key_level     <= ~key_level;     // Stable long enough, accept
            cnt           <= CW'(DEBOUNCE_CYCLES);
            start_pressed <= key_level;      // Only on released -> pressed
         end else begin
            cnt <= cnt - 1'b1;
         end
      end
   end

endmodule

/* verilog/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
   parameter int CLKS_PER_BIT = 434
) (
   input  logic       CLOCK_50,
   input  logic       rst,
   input  logic       rxd,                   // Serial line, idle high
   output logic [7:0] rx_byte,
   output logic       rx_valid,
   input  logic       rx_ready,
   output logic       overrun                // Sticky, byte lost while full
);

   localparam int CW = $clog2(CLKS_PER_BIT);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

   rx_state_e     state;
   logic [1:0]    rxd_sync;                  // Line synchroniser
   logic          rxd_s;
   logic [CW-1:0] bit_cnt;                   // Clocks to next sample point
   logic [2:0]    bit_idx;                   // Data bit number
   logic [7:0]    shift;                     // LSB first assembly
   logic          byte_done;                 // Good stop bit this cycle

   assign rxd_s     = rxd_sync[1];
   assign byte_done = (state == RX_STOP) && (bit_cnt == '0) && rxd_s;

   always_ff @(posedge CLOCK_50) begin
      if (rst) begin
         rxd_sync <= 2'b11;
         state    <= RX_IDLE;
         bit_cnt  <= '0;
         bit_idx  <= '0;
      end else begin
         rxd_sync <= {rxd_sync[0], rxd};
         case (state)
            RX_IDLE: if (!rxd_s) begin       // Start bit edge
               bit_cnt <= CW'(CLKS_PER_BIT / 2 - 1);
               state   <= RX_START;
            end
            RX_START: if (bit_cnt == '0) begin
               bit_cnt <= CW'(CLKS_PER_BIT - 1);
               bit_idx <= '0;
               state   <= rxd_s ? RX_IDLE : RX_DATA; // Glitch check at mid start
            end else begin
               bit_cnt <= bit_cnt - 1'b1;
            end
            RX_DATA: if (bit_cnt == '0) begin
               bit_cnt <= CW'(CLKS_PER_BIT - 1);
               bit_idx <= bit_idx + 1'b1;
               if (bit_idx == 3'd7) state <= RX_STOP;
            end else begin
               bit_cnt <= bit_cnt - 1'b1;
            end
            RX_STOP: if (bit_cnt == '0) begin
               state <= RX_IDLE;             // Low stop bit just drops the byte
            end else begin
               bit_cnt <= bit_cnt - 1'b1;
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // Shift register, sampled mid-bit
   always_ff @(posedge CLOCK_50) begin
      if (state == RX_DATA && bit_cnt == '0) shift <= {rxd_s, shift[7:1]};
   end

   // Holding register control
   always_ff @(posedge CLOCK_50) begin
      if (rst) begin
         rx_valid <= 1'b0;
         overrun  <= 1'b0;
      end else if (byte_done && rx_valid && !rx_ready) begin
         overrun <= 1'b1;                    // Still full, drop new byte
      end else if (byte_done) begin
         rx_valid <= 1'b1;
      end else if (rx_valid && rx_ready) begin
         rx_valid <= 1'b0;                   // Consumed
      end
   end

   always_ff @(posedge CLOCK_50) begin
      if (byte_done && !(rx_valid && !rx_ready)) rx_byte <= shift;
   end

   // Held byte must not move under back-pressure
   a_hold_stable: assert property (@(posedge CLOCK_50) disable iff (rst)
      rx_valid && !rx_ready |=> rx_valid && $stable(rx_byte));

endmodule

/* verilog/frame_parser.sv */
`timescale 1ns/1ps

module frame_parser (
   input  logic                CLOCK_50,
   input  logic                rst,
   input  logic [7:0]          rx_byte,
   input  logic                rx_valid,
   output logic                rx_ready,
   output feed_pkg::feed_cmd_t cmd,
   output logic                cmd_valid,    // One cycle per frame
   output logic                frame_err     // Sticky bad opcode
);

   feed_pkg::parse_state_e state;
   logic                   take;             // Byte handshake
   logic                   op_ok;            // Incoming byte is a known opcode

   assign rx_ready  = (state != feed_pkg::ST_ISSUE);
   assign take      = rx_valid && rx_ready;
   assign cmd_valid = (state == feed_pkg::ST_ISSUE);
   assign op_ok     = rx_byte inside {feed_pkg::OP_LED, feed_pkg::OP_GPS, feed_pkg::OP_STOP};

   always_ff @(posedge CLOCK_50) begin
      if (rst) begin
         state     <= feed_pkg::ST_SYNC;
         frame_err <= 1'b0;
      end else begin
         case (state)
            feed_pkg::ST_SYNC:
               if (take && rx_byte == feed_pkg::SYNC_BYTE) state <= feed_pkg::ST_OPCODE;
            feed_pkg::ST_OPCODE:
               if (take) begin
                  if (op_ok) begin
                     state <= feed_pkg::ST_DATA;
                  end else begin
                     frame_err <= 1'b1;      // Abandon frame
                     state     <= feed_pkg::ST_SYNC;
                  end
               end
            feed_pkg::ST_DATA:
               if (take) state <= feed_pkg::ST_ISSUE;
            feed_pkg::ST_ISSUE:
               state <= feed_pkg::ST_SYNC;   // cmd_valid high here
            default: state <= feed_pkg::ST_SYNC;
         endcase
      end
   end

   // Command payload capture
   always_ff @(posedge CLOCK_50) begin
      if (take && state == feed_pkg::ST_OPCODE) cmd.opcode <= feed_pkg::opcode_e'(rx_byte);
      if (take && state == feed_pkg::ST_DATA) cmd.data <= rx_byte;
   end

   a_single_pulse: assert property (@(posedge CLOCK_50) disable iff (rst)
      cmd_valid |=> !cmd_valid);

   a_cmd_opcode: assert property (@(posedge CLOCK_50) disable iff (rst)
      cmd_valid |-> cmd.opcode inside {feed_pkg::OP_LED, feed_pkg::OP_GPS, feed_pkg::OP_STOP});

endmodule

/* verilog/feed_regs.sv */
`timescale 1ns/1ps

module feed_regs (
   input  logic                CLOCK_50,
   input  logic                rst,
   input  feed_pkg::feed_cmd_t cmd,
   input  logic                cmd_valid,
   input  logic                start_pressed,
   output logic [7:0]          leds,
   output logic [7:0]          gps,
   output logic                armed
);

   always_ff @(posedge CLOCK_50) begin
      if (rst) begin
         leds  <= '0;
         gps   <= '0;
         armed <= 1'b0;
      end else begin
         if (start_pressed) armed <= 1'b1;
         if (cmd_valid) begin
            case (cmd.opcode)
               feed_pkg::OP_LED:  if (armed) leds <= cmd.data;
               feed_pkg::OP_GPS:  if (armed) gps <= cmd.data;
               feed_pkg::OP_STOP: armed <= 1'b0;   // Stop beats a same-cycle press
               default: ;
            endcase
         end
      end
   end

   // Disarmed block holds its LED value
   a_leds_locked: assert property (@(posedge CLOCK_50) disable iff (rst)
      !armed |=> $stable(leds));

endmodule

/* verilog/hex_driver.sv */
`timescale 1ns/1ps

module hex_driver (
   input  logic [3:0]       nibble,
   output board_pkg::seg7_t seg              // g..a, low = lit
);

   always_comb begin
      case (nibble)
         4'h0: seg = 7'h40;
         4'h1: seg = 7'h79;
         4'h2: seg = 7'h24;
         4'h3: seg = 7'h30;
         4'h4: seg = 7'h19;
         4'h5: seg = 7'h12;
         4'h6: seg = 7'h02;
         4'h7: seg = 7'h78;
         4'h8: seg = 7'h00;
         4'h9: seg = 7'h10;
         4'hA: seg = 7'h08;
         4'hB: seg = 7'h03;                  // Lower case b
         4'hC: seg = 7'h46;
         4'hD: seg = 7'h21;                  // Lower case d
         4'hE: seg = 7'h06;
         default: seg = 7'h0E;               // F
      endcase
   end

endmodule

/* verilog/data_feed_top.sv */
`timescale 1ns/1ps

module data_feed_top #(
   parameter int CLKS_PER_BIT    = 434,      // 115200 baud at 50 MHz
   parameter int DEBOUNCE_CYCLES = 100
) (
   input  logic             CLOCK_50,
   input  logic             rst,
   input  logic [3:0]       key,             // Push buttons, active low
   input  logic             uart_rxd,
   output board_pkg::seg7_t hex0,
   output board_pkg::seg7_t hex1,
   output board_pkg::seg7_t hex4,
   output board_pkg::seg7_t hex5,
   output logic [17:0]      ledr,
   output logic [8:0]       ledg
);

   logic [7:0]          rx_byte;
   logic                rx_valid;
   logic                rx_ready;
   feed_pkg::feed_cmd_t cmd;
   logic                cmd_valid;
   logic                start_pressed;
   board_pkg::disp_t    disp;            // Collected display state

   key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_key_debounce (
      .CLOCK_50(CLOCK_50), .rst(rst), .key_n(key[3]), .start_pressed(start_pressed));

   uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
      .CLOCK_50(CLOCK_50), .rst(rst), .rxd(uart_rxd),
      .rx_byte(rx_byte), .rx_valid(rx_valid), .rx_ready(rx_ready),
      .overrun(disp.overrun));

   frame_parser u_frame_parser (
      .CLOCK_50(CLOCK_50), .rst(rst),
      .rx_byte(rx_byte), .rx_valid(rx_valid), .rx_ready(rx_ready),
      .cmd(cmd), .cmd_valid(cmd_valid), .frame_err(disp.frame_err));

   feed_regs u_feed_regs (
      .CLOCK_50(CLOCK_50), .rst(rst),
      .cmd(cmd), .cmd_valid(cmd_valid), .start_pressed(start_pressed),
      .leds(disp.leds), .gps(disp.gps), .armed(disp.armed));

   // LED value as two hex digits
   hex_driver u_hex0 (.nibble(disp.leds[3:0]), .seg(hex0));
   hex_driver u_hex1 (.nibble(disp.leds[7:4]), .seg(hex1));

   // GPS low bits as one digit
   hex_driver u_hex4 (.nibble({2'b00, disp.gps[1:0]}), .seg(hex4));

   assign hex5 = {~disp.gps[2], 6'h3F};      // Only g used, fix indicator

   assign ledr = {disp.leds, 10'h000};
   assign ledg = {disp.gps[3:0], 2'b00, disp.overrun, disp.frame_err, disp.armed};

endmodule

/* tests/tb_data_feed_top.sv */
`timescale 1ns/1ps

module tb_data_feed_top;

   localparam int CLKS_PER_BIT    = 8;
   localparam int DEBOUNCE_CYCLES = 10;
   localparam int WAIT_LIMIT      = 2000;    // Cycles before a wait gives up

   logic             CLOCK_50;
   logic             rst;
   logic [3:0]       key;
   logic             uart_rxd;
   board_pkg::seg7_t hex0, hex1, hex4, hex5;
   logic [17:0]      ledr;
   logic [8:0]       ledg;

   logic       m_armed;                      // Model of the register block
   logic [7:0] m_leds;
   logic [7:0] m_gps;
   logic       bad_sent;                     // A bad opcode has gone out
   logic       press_pending;                // Press issued but not yet seen
   logic       exp_known;                    // exp_cmd holds the next command
   feed_pkg::feed_cmd_t exp_cmd;
   feed_pkg::feed_cmd_t exp_q[$];            // Frames sent but not yet issued
   integer     seed = 32'h085d_1518;

   data_feed_top #(.CLKS_PER_BIT(CLKS_PER_BIT), .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES))
   u_data_feed_top (
      .CLOCK_50(CLOCK_50), .rst(rst), .key(key), .uart_rxd(uart_rxd),
      .hex0(hex0), .hex1(hex1), .hex4(hex4), .hex5(hex5), .ledr(ledr), .ledg(ledg));

   initial begin
      CLOCK_50 = 1'b0;
      forever #20 CLOCK_50 = ~CLOCK_50;      // 25 MHz in sim with a 40 ns period
   end

   task automatic fail_stop();
      $display("=== FAIL ===");
      $fatal(1, "Stopped at first failure");
   endtask

   task automatic value_error(input string name, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
      $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp_v, act_v);
      fail_stop();
   endtask

   // Active-low pattern of one hex digit from its lit segments g..a
   function automatic board_pkg::seg7_t seg_of(input logic [3:0] d);
      logic [6:0] lit;
      case (d)
         4'h0: lit = 7'b0111111;
         4'h1: lit = 7'b0000110;
         4'h2: lit = 7'b1011011;
         4'h3: lit = 7'b1001111;
         4'h4: lit = 7'b1100110;
         4'h5: lit = 7'b1101101;
         4'h6: lit = 7'b1111101;
         4'h7: lit = 7'b0000111;
         4'h8: lit = 7'b1111111;
         4'h9: lit = 7'b1101111;
         4'hA: lit = 7'b1110111;
         4'hB: lit = 7'b1111100;             // b
         4'hC: lit = 7'b0111001;
         4'hD: lit = 7'b1011110;             // d
         4'hE: lit = 7'b1111001;
         default: lit = 7'b1110001;          // F
      endcase
      return ~lit;
   endfunction

   // One 8N1 character sent LSB first
   task automatic send_byte(input logic [7:0] b);
      uart_rxd = 1'b0;
      repeat (CLKS_PER_BIT) @(negedge CLOCK_50);
      for (int i = 0; i < 8; i++) begin
         uart_rxd = b[i];
         repeat (CLKS_PER_BIT) @(negedge CLOCK_50);
      end
      uart_rxd = 1'b1;
      repeat (CLKS_PER_BIT) @(negedge CLOCK_50);
   endtask

   task automatic send_frame(input feed_pkg::opcode_e op, input logic [7:0] d, input int gap);
      feed_pkg::feed_cmd_t c;
      c.opcode = op;
      c.data   = d;
      exp_q.push_back(c);                    // Expected in send order
      send_byte(feed_pkg::SYNC_BYTE);
      send_byte(8'(op));
      send_byte(d);
      repeat (gap) @(negedge CLOCK_50);      // Zero gap gives back to back frames
   endtask

   task automatic wait_drain();
      int n = 0;
      while ((exp_q.size() != 0 || exp_known) && n < WAIT_LIMIT) begin
         @(negedge CLOCK_50);
         n++;
      end
      if (exp_q.size() != 0 || exp_known) begin
         $display("Sent frames were not all issued as commands in time");
         fail_stop();
      end
      @(negedge CLOCK_50);
   endtask

   task automatic wait_frame_err();
      int n = 0;
      while (!ledg[1] && n < WAIT_LIMIT) begin
         @(negedge CLOCK_50);
         n++;
      end
      if (!ledg[1]) begin
         $display("Frame error LED did not light after a bad opcode");
         fail_stop();
      end
   endtask

   task automatic press_start();
      int n = 0;
      press_pending = 1'b1;
      key[3]        = 1'b0;                  // Held down through debounce
      while (press_pending && n < WAIT_LIMIT) begin
         @(negedge CLOCK_50);
         n++;
      end
      if (press_pending) begin
         $display("Start key press was never accepted");
         fail_stop();
      end
      key[3] = 1'b1;
      repeat (DEBOUNCE_CYCLES + 4) @(negedge CLOCK_50); // Release settles
   endtask

   // Model follows each issued command one edge after the DUT takes it
   always begin
      @(negedge CLOCK_50);
      if (!rst && u_data_feed_top.cmd_valid) begin
         exp_known = (exp_q.size() != 0);
         if (exp_known) exp_cmd = exp_q.pop_front();
         @(negedge CLOCK_50);
         if (exp_known) begin
            case (exp_cmd.opcode)
               feed_pkg::OP_LED:  if (m_armed) m_leds = exp_cmd.data;
               feed_pkg::OP_GPS:  if (m_armed) m_gps = exp_cmd.data;
               feed_pkg::OP_STOP: m_armed = 1'b0;
               default: ;
            endcase
         end
         exp_known = 1'b0;
      end
   end

   always begin
      @(negedge CLOCK_50);
      if (!rst && u_data_feed_top.start_pressed) begin
         @(negedge CLOCK_50);
         m_armed       = 1'b1;
         press_pending = 1'b0;
      end
   end

   a_cmd: assert property (@(posedge CLOCK_50) disable iff (rst)
      u_data_feed_top.cmd_valid |-> exp_known && u_data_feed_top.cmd == exp_cmd)
      else value_error("cmd", 32'(exp_cmd), 32'($sampled(u_data_feed_top.cmd)));
   a_press: assert property (@(posedge CLOCK_50) disable iff (rst)
      u_data_feed_top.start_pressed |-> press_pending)
      else value_error("start_pressed", 32'(press_pending), 32'd1);
   a_parser_idle: assert property (@(posedge CLOCK_50)
      rst |=> u_data_feed_top.u_frame_parser.state == feed_pkg::ST_SYNC)
      else value_error("parser state", 32'(feed_pkg::ST_SYNC),
                       32'($sampled(u_data_feed_top.u_frame_parser.state)));
   a_ledr: assert property (@(posedge CLOCK_50) disable iff (rst)
      ledr[17:10] == m_leds && ledr[9:0] == 10'h000)
      else value_error("ledr", 32'({m_leds, 10'h000}), 32'($sampled(ledr)));
   a_hex0: assert property (@(posedge CLOCK_50) disable iff (rst) hex0 == seg_of(m_leds[3:0]))
      else value_error("hex0", 32'(seg_of(m_leds[3:0])), 32'($sampled(hex0)));
   a_hex1: assert property (@(posedge CLOCK_50) disable iff (rst) hex1 == seg_of(m_leds[7:4]))
      else value_error("hex1", 32'(seg_of(m_leds[7:4])), 32'($sampled(hex1)));
   a_hex4: assert property (@(posedge CLOCK_50) disable iff (rst)
      hex4 == seg_of({2'b00, m_gps[1:0]}))
      else value_error("hex4", 32'(seg_of({2'b00, m_gps[1:0]})), 32'($sampled(hex4)));
   // Blank digit without a fix, only segment g lit with one
   a_hex5: assert property (@(posedge CLOCK_50) disable iff (rst)
      hex5 == (m_gps[2] ? 7'h3F : 7'h7F))
      else value_error("hex5", 32'(m_gps[2] ? 7'h3F : 7'h7F), 32'($sampled(hex5)));
   a_ledg: assert property (@(posedge CLOCK_50) disable iff (rst)
      ledg[0] == m_armed && ledg[8:5] == m_gps[3:0] && ledg[4:2] == 3'b000)
      else value_error("ledg", 32'({m_gps[3:0], 4'b0000, m_armed}), 32'($sampled(ledg) & 9'h1FD));
   a_err_cause: assert property (@(posedge CLOCK_50) disable iff (rst) ledg[1] |-> bad_sent)
      else value_error("ledg[1]", 32'(bad_sent), 32'($sampled(ledg[1])));
   a_err_sticky: assert property (@(posedge CLOCK_50) disable iff (rst) ledg[1] |=> ledg[1])
      else value_error("ledg[1]", 32'd1, 32'($sampled(ledg[1])));

   initial begin
      rst           = 1'b1;
      key           = 4'hF;                  // All released
      uart_rxd      = 1'b1;                  // Line idle
      m_armed       = 1'b0;
      m_leds        = '0;
      m_gps         = '0;
      bad_sent      = 1'b0;
      press_pending = 1'b0;
      exp_known     = 1'b0;
      exp_cmd       = '0;
      repeat (16) @(negedge CLOCK_50);
      rst = 1'b0;
      repeat (4) @(negedge CLOCK_50);
      send_frame(feed_pkg::OP_LED, 8'h5C, 12); // Not armed yet so ignored
      wait_drain();
      press_start();
      for (int i = 0; i < 4; i++) send_frame(feed_pkg::OP_LED, 8'($random(seed)), 12);
      wait_drain();
      send_frame(feed_pkg::OP_GPS, 8'h04, 12); // Fix bit set
      send_frame(feed_pkg::OP_GPS, 8'h0B, 12); // Fix bit clear
      for (int i = 0; i < 3; i++) send_frame(feed_pkg::OP_GPS, 8'($random(seed)), 12);
      wait_drain();
      send_byte(8'h5A);                      // Noise ahead of the sync byte
      send_byte(8'h01);
      send_byte(8'hFF);
      send_frame(feed_pkg::OP_LED, 8'($random(seed)), 12);
      wait_drain();
      bad_sent = 1'b1;
      send_byte(feed_pkg::SYNC_BYTE);
      send_byte(8'h7E);                      // Unknown opcode
      wait_frame_err();
      send_frame(feed_pkg::OP_GPS, 8'($random(seed)), 12);
      wait_drain();
      send_frame(feed_pkg::OP_STOP, 8'h00, 12);
      send_frame(feed_pkg::OP_LED, 8'($random(seed)), 12);
      send_frame(feed_pkg::OP_GPS, 8'($random(seed)), 12);
      wait_drain();
      press_start();
      send_frame(feed_pkg::OP_LED, 8'($random(seed)), 12);
      wait_drain();
      for (int i = 0; i < 6; i++) begin      // Back to back with no idle
         send_frame((i % 2 == 0) ? feed_pkg::OP_LED : feed_pkg::OP_GPS,
                    8'($random(seed)), 0);
      end
      wait_drain();
      repeat (20) @(negedge CLOCK_50);
      $display("=== PASS ===");
      $finish;
   end

endmodule

/* data_feed_top.f */
verilog/feed_pkg.sv
verilog/board_pkg.sv
verilog/key_debounce.sv
verilog/uart_rx.sv
verilog/frame_parser.sv
verilog/feed_regs.sv
verilog/hex_driver.sv
verilog/data_feed_top.sv
tests/tb_data_feed_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the data feed testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   --top-module tb_data_feed_top \
   -f data_feed_top.f \
   -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "=== PASS ===" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
